// ==== afifo_cfg_pkg.sv ====
`default_nettype none

package afifo_cfg_pkg;

   // address bits of the storage array
   localparam int ADDR_W = 3;

   // words the FIFO can hold
   localparam int DEPTH = 1 << ADDR_W;

   // width of one FIFO word
   localparam int DATA_W = 16;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] addr_t;

   // one extra bit tells a full FIFO from an empty one
   typedef logic [ADDR_W:0] ptr_t;

   // occupancy from 0 up to DEPTH
   typedef logic [ADDR_W:0] level_t;

endpackage

`default_nettype wire

// ==== afifo_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module afifo_ctrl (
   input  wire                          w_clk_i,
   input  wire                          r_clk_i,
   input  wire                          reset_i,
   input  wire                          w_en_i,
   input  wire                          r_en_i,
   input  afifo_cfg_pkg::data_t         w_data_i,
   input  afifo_cfg_pkg::ptr_t          w_wptr_i,
   input  afifo_cfg_pkg::ptr_t          w_rptr_i,
   input  afifo_cfg_pkg::ptr_t          r_rptr_i,
   input  afifo_cfg_pkg::ptr_t          r_wptr_i,
   output logic                         w_acc_o,
   output logic                         r_acc_o,
   output afifo_types_pkg::wr_req_t     wr_o,
   output afifo_cfg_pkg::addr_t         rd_addr_o,
   output afifo_types_pkg::dom_status_t w_status_o,
   output afifo_types_pkg::dom_status_t r_status_o,
   output logic                         r_valid_o
);

   localparam afifo_cfg_pkg::level_t FULL_LEVEL = afifo_cfg_pkg::level_t'(afifo_cfg_pkg::DEPTH);

   afifo_cfg_pkg::level_t w_level;
   afifo_cfg_pkg::level_t r_level;
   logic                  r_valid_q;

   // write domain view, own pointer against the synced read pointer
   assign w_level           = w_wptr_i - w_rptr_i;
   assign w_status_o.level  = w_level;
   assign w_status_o.empty  = (w_level == '0);
   assign w_status_o.full   = (w_level == FULL_LEVEL);

   // read domain view
   assign r_level           = r_wptr_i - r_rptr_i;
   assign r_status_o.level  = r_level;
   assign r_status_o.empty  = (r_level == '0);
   assign r_status_o.full   = (r_level == FULL_LEVEL);

   // overflow and underflow protection
   assign w_acc_o = w_en_i & ~w_status_o.full;
   assign r_acc_o = r_en_i & ~r_status_o.empty;

   assign wr_o.en   = w_acc_o;
   assign wr_o.addr = w_wptr_i[afifo_cfg_pkg::ADDR_W-1:0];
   assign wr_o.data = w_data_i;

   assign rd_addr_o = r_rptr_i[afifo_cfg_pkg::ADDR_W-1:0];

   // data leaves the ram register on the same edge
   always_ff @(posedge r_clk_i) begin
      if (reset_i) begin
         r_valid_q <= 1'b0;
      end else begin
         r_valid_q <= r_acc_o;
      end
   end

   assign r_valid_o = r_valid_q;

   // stale remote pointers may only make the FIFO look fuller or emptier, never overfull
   a_w_level_max : assert property (@(posedge w_clk_i) disable iff (reset_i)
      w_level <= FULL_LEVEL)
      else $error("write side level above depth");

   a_r_level_max : assert property (@(posedge r_clk_i) disable iff (reset_i)
      r_level <= FULL_LEVEL)
      else $error("read side level above depth");

   // write pointer stays put across a full cycle
   a_no_write_when_full : assert property (@(posedge w_clk_i) disable iff (reset_i)
      w_status_o.full |=> $stable(w_wptr_i))
      else $error("write pointer moved while full");

   // read pointer stays put across an empty cycle
   a_no_read_when_empty : assert property (@(posedge r_clk_i) disable iff (reset_i)
      r_status_o.empty |=> $stable(r_rptr_i))
      else $error("read pointer moved while empty");

endmodule

`default_nettype wire

// ==== afifo_input.txt ====
# columns: operation, cycle count, expected level after settling
# operation: W write, R read, B write and read together, I idle
W 5 5
R 2 3
W 10 8
W 2 8
R 4 4
B 20 4
I 3 4
B 16 4
R 10 0
R 3 0
I 4 0
W 8 8
R 4 4
B 12 4
R 6 0
W 3 3
R 1 2
W 2 4
B 8 4
R 4 0

// ==== afifo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module afifo_top (
   input  wire                          w_clk_i,
   input  wire                          r_clk_i,
   input  wire                          reset_i,
   input  wire                          w_en_i,
   input  afifo_cfg_pkg::data_t         w_data_i,
   output afifo_types_pkg::dom_status_t w_status_o,
   input  wire                          r_en_i,
   output afifo_cfg_pkg::data_t         r_data_o,
   output logic                         r_valid_o,
   output afifo_types_pkg::dom_status_t r_status_o
);

   logic                     w_acc;
   logic                     r_acc;
   afifo_cfg_pkg::ptr_t      w_wptr;
   afifo_cfg_pkg::ptr_t      w_wptr_gray;
   afifo_cfg_pkg::ptr_t      r_rptr;
   afifo_cfg_pkg::ptr_t      r_rptr_gray;
   // pointers seen from the other domain
   afifo_cfg_pkg::ptr_t      r_wptr;
   afifo_cfg_pkg::ptr_t      w_rptr;
   afifo_types_pkg::wr_req_t wr_req;
   afifo_cfg_pkg::addr_t     rd_addr;

   afifo_ctrl ctrl0 (
      .w_clk_i   (w_clk_i),
      .r_clk_i   (r_clk_i),
      .reset_i   (reset_i),
      .w_en_i    (w_en_i),
      .r_en_i    (r_en_i),
      .w_data_i  (w_data_i),
      .w_wptr_i  (w_wptr),
      .w_rptr_i  (w_rptr),
      .r_rptr_i  (r_rptr),
      .r_wptr_i  (r_wptr),
      .w_acc_o   (w_acc),
      .r_acc_o   (r_acc),
      .wr_o      (wr_req),
      .rd_addr_o (rd_addr),
      .w_status_o(w_status_o),
      .r_status_o(r_status_o),
      .r_valid_o (r_valid_o)
   );

   // write pointer, write domain
   gray_ptr_counter wptr0 (
      .clk_i  (w_clk_i),
      .reset_i(reset_i),
      .inc_i  (w_acc),
      .bin_o  (w_wptr),
      .gray_o (w_wptr_gray)
   );

   // read pointer, read domain
   gray_ptr_counter rptr0 (
      .clk_i  (r_clk_i),
      .reset_i(reset_i),
      .inc_i  (r_acc),
      .bin_o  (r_rptr),
      .gray_o (r_rptr_gray)
   );

   // write pointer into the read domain
   gray_ptr_sync wsync0 (
      .clk_i  (r_clk_i),
      .reset_i(reset_i),
      .gray_i (w_wptr_gray),
      .bin_o  (r_wptr)
   );

   // read pointer into the write domain
   gray_ptr_sync rsync0 (
      .clk_i  (w_clk_i),
      .reset_i(reset_i),
      .gray_i (r_rptr_gray),
      .bin_o  (w_rptr)
   );

   dual_clock_ram ram0 (
      .w_clk_i  (w_clk_i),
      .wr_i     (wr_req),
      .r_clk_i  (r_clk_i),
      .rd_en_i  (r_acc),
      .rd_addr_i(rd_addr),
      .rd_data_o(r_data_o)
   );

endmodule

`default_nettype wire

// ==== afifo_types_pkg.sv ====
`default_nettype none

package afifo_types_pkg;

   // accepted write toward the storage array
   typedef struct packed {
      logic                 en;
      afifo_cfg_pkg::addr_t addr;
      afifo_cfg_pkg::data_t data;
   } wr_req_t;

   // status as seen from one clock domain
   typedef struct packed {
      afifo_cfg_pkg::level_t level;
      logic                  empty;
      logic                  full;
   } dom_status_t;

endpackage

`default_nettype wire

// ==== dual_clock_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_clock_ram (
   input  wire                      w_clk_i,
   input  afifo_types_pkg::wr_req_t wr_i,
   input  wire                      r_clk_i,
   input  wire                      rd_en_i,
   input  afifo_cfg_pkg::addr_t     rd_addr_i,
   output afifo_cfg_pkg::data_t     rd_data_o
);

   afifo_cfg_pkg::data_t mem [afifo_cfg_pkg::DEPTH];
   afifo_cfg_pkg::data_t rd_data_q;

   // write port, write domain
   always_ff @(posedge w_clk_i) begin
      if (wr_i.en) begin
         mem[wr_i.addr] <= wr_i.data;
      end
   end

   // registered read port, holds its word between reads
   always_ff @(posedge r_clk_i) begin
      if (rd_en_i) begin
         rd_data_q <= mem[rd_addr_i];
      end
   end

   assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

// ==== gray_ptr_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_counter (
   input  wire                 clk_i,
   input  wire                 reset_i,
   input  wire                 inc_i,
   output afifo_cfg_pkg::ptr_t bin_o,
   output afifo_cfg_pkg::ptr_t gray_o
);

   afifo_cfg_pkg::ptr_t bin_q;
   afifo_cfg_pkg::ptr_t gray_q;
   afifo_cfg_pkg::ptr_t bin_next;

   // wraps naturally at 2**(ADDR_W+1)
   assign bin_next = bin_q + afifo_cfg_pkg::ptr_t'(1);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         bin_q  <= '0;
         gray_q <= '0;
      end else if (inc_i) begin
         bin_q  <= bin_next;
         // gray copy is a flop so the other domain never samples a decoder glitch
         gray_q <= bin_next ^ (bin_next >> 1);
      end
   end

   assign bin_o  = bin_q;
   assign gray_o = gray_q;

   // a single bit may flip per step, otherwise the synchronizer can see a bogus value
   a_gray_one_bit : assert property (@(posedge clk_i) disable iff (reset_i)
      $countones(gray_q ^ $past(gray_q)) <= 1)
      else $error("gray pointer changed in more than one bit");

endmodule

`default_nettype wire

// ==== gray_ptr_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_sync (
   input  wire                 clk_i,
   input  wire                 reset_i,
   input  afifo_cfg_pkg::ptr_t gray_i,
   output afifo_cfg_pkg::ptr_t bin_o
);

   afifo_cfg_pkg::ptr_t sync1_q;
   afifo_cfg_pkg::ptr_t sync2_q;

   // cumulative xor from the top bit down
   function automatic afifo_cfg_pkg::ptr_t gray2bin(input afifo_cfg_pkg::ptr_t g);
      afifo_cfg_pkg::ptr_t b;
      b[afifo_cfg_pkg::ADDR_W] = g[afifo_cfg_pkg::ADDR_W];
      for (int i = afifo_cfg_pkg::ADDR_W - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // first stage may go metastable, second stage settles it
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         sync1_q <= '0;
         sync2_q <= '0;
      end else begin
         sync1_q <= gray_i;
         sync2_q <= sync1_q;
      end
   end

   // only the settled stage is decoded
   assign bin_o = gray2bin(sync2_q);

endmodule

`default_nettype wire

// ==== project.f ====
afifo_cfg_pkg.sv
afifo_types_pkg.sv
gray_ptr_counter.sv
gray_ptr_sync.sv
dual_clock_ram.sv
afifo_ctrl.sv
afifo_top.sv
tb_afifo.sv

// ==== run.sh ====
#!/bin/sh
# build and run the FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_afifo

# the simulator exits non-zero on failure, the log decides the verdict
./obj_dir/Vtb_afifo > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

// ==== tb_afifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_afifo;

   localparam afifo_cfg_pkg::level_t LEVEL_MAX = afifo_cfg_pkg::level_t'(afifo_cfg_pkg::DEPTH);

   logic                         w_clk_i;
   logic                         r_clk_i;
   logic                         reset_i;
   logic                         w_en_i;
   logic                         r_en_i;
   afifo_cfg_pkg::data_t         w_data_i;
   afifo_cfg_pkg::data_t         r_data_o;
   logic                         r_valid_o;
   afifo_types_pkg::dom_status_t w_status_o;
   afifo_types_pkg::dom_status_t r_status_o;

   // reference model and the records from the data file
   afifo_cfg_pkg::data_t model_q[$];
   logic [7:0]           rec_op[$];
   int                   rec_cnt[$];
   int                   rec_lvl[$];
   logic [31:0]          lcg_state;
   int                   cycle_limit = 0;
   int                   cycle_cnt = 0;
   logic                 running = 1'b0;

   afifo_top dut0 (
      .w_clk_i   (w_clk_i),
      .r_clk_i   (r_clk_i),
      .reset_i   (reset_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .w_status_o(w_status_o),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_valid_o (r_valid_o),
      .r_status_o(r_status_o)
   );

   initial begin
      w_clk_i = 1'b0;
      forever #5 w_clk_i = ~w_clk_i;
   end

   // read clock lags by 3 ns
   initial begin
      r_clk_i = 1'b0;
      #3;
      forever #5 r_clk_i = ~r_clk_i;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic abort_run();
      $display("** FAIL **");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // level range and flag rules hold in every cycle
   task automatic check_flags(input string name, input afifo_types_pkg::dom_status_t st);
      assert (st.level <= LEVEL_MAX) else begin
         $display("Mismatch %s.level: got %h, above %h", name, st.level, LEVEL_MAX);
         abort_run();
      end
      assert (st.empty == (st.level == '0)) else begin
         $display("Mismatch %s.empty: got %h expected %h", name, st.empty, st.level == '0);
         abort_run();
      end
      assert (st.full == (st.level == LEVEL_MAX)) else begin
         $display("Mismatch %s.full: got %h expected %h", name, st.full, st.level == LEVEL_MAX);
         abort_run();
      end
   endtask

   task automatic load_records();
      int         fd;
      int         n;
      int         cnt;
      int         lvl;
      logic [7:0] op;
      string      line;
      fd = $fopen("afifo_input.txt", "r");
      if (fd == 0) begin
         $display("could not open afifo_input.txt");
         abort_run();
      end
      while ($fgets(line, fd) > 0) begin
         if (line.len() > 1 && line.getc(0) != "#") begin
            n = $sscanf(line, "%c %d %d", op, cnt, lvl);
            if (n != 3) begin
               $display("malformed record line in afifo_input.txt: %s", line);
               abort_run();
            end
            rec_op.push_back(op);
            rec_cnt.push_back(cnt);
            rec_lvl.push_back(lvl);
         end
      end
      $fclose(fd);
   endtask

   task automatic write_phase(input logic [7:0] op, input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge w_clk_i);
         check_flags("w_status_o", w_status_o);
         // with no reads in flight the write side view is exact
         if (op == "W") begin
            assert (int'(w_status_o.level) == model_q.size()) else begin
               $display("Mismatch w_status_o.level: got %h expected %h",
                        w_status_o.level, model_q.size());
               abort_run();
            end
         end
         lcg_state = lcg_next(lcg_state);
         w_data_i  = lcg_state[31:16];
         w_en_i    = 1'b1;
         if (!w_status_o.full) begin
            model_q.push_back(w_data_i);
         end
      end
      @(negedge w_clk_i);
      w_en_i = 1'b0;
   endtask

   task automatic read_phase(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge r_clk_i);
         r_en_i = 1'b1;
      end
      @(negedge r_clk_i);
      r_en_i = 1'b0;
   endtask

   task automatic check_settled(input int lvl);
      repeat (8) @(negedge w_clk_i);
      assert (int'(w_status_o.level) == lvl) else begin
         $display("Mismatch w_status_o.level: got %h expected %h", w_status_o.level, lvl);
         abort_run();
      end
      assert (int'(r_status_o.level) == lvl) else begin
         $display("Mismatch r_status_o.level: got %h expected %h", r_status_o.level, lvl);
         abort_run();
      end
      assert (model_q.size() == lvl) else begin
         $display("Mismatch model_q.size: got %h expected %h", model_q.size(), lvl);
         abort_run();
      end
   endtask

   // read side monitor, outputs settle half a cycle after the rising edge
   initial begin
      afifo_cfg_pkg::data_t expected;
      wait (running);
      forever begin
         @(negedge r_clk_i);
         if (r_valid_o) begin
            assert (model_q.size() > 0) else begin
               $display("r_valid_o pulsed although every written word was already read");
               abort_run();
            end
            expected = model_q.pop_front();
            assert (r_data_o === expected) else begin
               $display("Mismatch r_data_o: got %h expected %h", r_data_o, expected);
               abort_run();
            end
         end
         check_flags("r_status_o", r_status_o);
         // a stale write pointer may only understate the level
         assert (int'(r_status_o.level) <= model_q.size()) else begin
            $display("Mismatch r_status_o.level: got %h, model holds %h",
                     r_status_o.level, model_q.size());
            abort_run();
         end
      end
   end

   initial begin
      wait (cycle_limit > 0);
      forever begin
         @(posedge w_clk_i);
         cycle_cnt++;
         if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the test did not end within %0d write clock cycles", cycle_limit);
            abort_run();
         end
      end
   end

   initial begin
      afifo_types_pkg::dom_status_t idle_st;
      int                           total;
      reset_i   = 1'b1;
      w_en_i    = 1'b0;
      r_en_i    = 1'b0;
      w_data_i  = '0;
      lcg_state = 32'd49978;
      load_records();
      total = 0;
      foreach (rec_cnt[i]) total += rec_cnt[i];
      cycle_limit = total + 20 * rec_cnt.size() + 100;

      repeat (2) @(posedge w_clk_i);
      @(negedge w_clk_i);
      idle_st.level = '0;
      idle_st.empty = 1'b1;
      idle_st.full  = 1'b0;
      assert (w_status_o === idle_st && r_status_o === idle_st && r_valid_o === 1'b0) else begin
         $display("Mismatch reset state: w_status_o %h r_status_o %h r_valid_o %h expected %h %h 0",
                  w_status_o, r_status_o, r_valid_o, idle_st, idle_st);
         abort_run();
      end
      reset_i = 1'b0;
      running = 1'b1;

      foreach (rec_op[k]) begin
         fork
            begin
               if (rec_op[k] == "W" || rec_op[k] == "B") write_phase(rec_op[k], rec_cnt[k]);
               else repeat (rec_cnt[k]) @(negedge w_clk_i);
            end
            begin
               if (rec_op[k] == "R" || rec_op[k] == "B") read_phase(rec_cnt[k]);
            end
         join
         check_settled(rec_lvl[k]);
      end

      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire
